// ==== rtl/cpu_core_pkg.sv ====
`default_nettype none

package cpu_core_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;

    // trace port byte enables for a full word write
    localparam logic [3:0] trace_we_ones = 4'hf;

    typedef logic [xlen-1:0]              word_t;
    typedef logic [2*xlen-1:0]            dword_t;
    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

    typedef struct packed {
        word_t quotient;
        word_t remainder;
    } div_result_t;

    // request word shared by multiplier and divider
    typedef struct packed {
        logic is_signed;
    } muldiv_op_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

    // field positions in the instruction word
    localparam int rd_lo      = 0;
    localparam int rj_lo      = 5;
    localparam int rk_lo      = 10;
    localparam int si12_lo    = 10;
    localparam int si20_lo    = 5;
    localparam int op3r_lo    = 15;
    localparam int op3r_w     = 17;
    localparam int op2ri12_lo = 22;
    localparam int op2ri12_w  = 10;
    localparam int op1ri20_lo = 25;
    localparam int op1ri20_w  = 7;

    // 3R format
    localparam logic [op3r_w-1:0] opc_add_w   = 17'h00020;
    localparam logic [op3r_w-1:0] opc_sub_w   = 17'h00022;
    localparam logic [op3r_w-1:0] opc_slt     = 17'h00024;
    localparam logic [op3r_w-1:0] opc_sltu    = 17'h00025;
    localparam logic [op3r_w-1:0] opc_nor     = 17'h00028;
    localparam logic [op3r_w-1:0] opc_and     = 17'h00029;
    localparam logic [op3r_w-1:0] opc_or      = 17'h0002a;
    localparam logic [op3r_w-1:0] opc_xor     = 17'h0002b;
    localparam logic [op3r_w-1:0] opc_sll_w   = 17'h0002e;
    localparam logic [op3r_w-1:0] opc_srl_w   = 17'h0002f;
    localparam logic [op3r_w-1:0] opc_sra_w   = 17'h00030;
    localparam logic [op3r_w-1:0] opc_mul_w   = 17'h00038;
    localparam logic [op3r_w-1:0] opc_mulh_w  = 17'h00039;
    localparam logic [op3r_w-1:0] opc_mulh_wu = 17'h0003a;
    localparam logic [op3r_w-1:0] opc_div_w   = 17'h00040;
    localparam logic [op3r_w-1:0] opc_mod_w   = 17'h00041;
    localparam logic [op3r_w-1:0] opc_div_wu  = 17'h00042;
    localparam logic [op3r_w-1:0] opc_mod_wu  = 17'h00043;

    localparam logic [op2ri12_w-1:0] opc_addi_w  = 10'h00a;
    localparam logic [op1ri20_w-1:0] opc_lu12i_w = 7'h0a;

    typedef enum logic [4:0] {
        op_none, op_add, op_sub, op_slt, op_sltu, op_and, op_or, op_nor,
        op_xor, op_sll, op_srl, op_sra, op_addi, op_lu12i, op_mul, op_mulh,
        op_mulhu, op_div, op_mod, op_divu, op_modu
    } exec_op_e;

endpackage

`default_nettype wire

// ==== rtl/exec_unit_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exec_unit_if #(
    parameter type op_t     = cpu_core_pkg::muldiv_op_t,
    parameter type result_t = cpu_core_pkg::dword_t
);
    import cpu_core_pkg::*;

    logic    req;
    logic    ack;
    op_t     op;
    word_t   src1;
    word_t   src2;
    // valid while ack is high
    result_t result;

    modport unit_ctrl (output req, op, src1, src2, input ack, result);

    modport unit_dp (input req, op, src1, src2, output ack, result);

endinterface

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                   clk,
    input  cpu_core_pkg::reg_idx_t raddr1,
    input  cpu_core_pkg::reg_idx_t raddr2,
    output cpu_core_pkg::word_t    rdata1,
    output cpu_core_pkg::word_t    rdata2,
    input  logic                   we,
    input  cpu_core_pkg::reg_idx_t waddr,
    input  cpu_core_pkg::word_t    wdata
);
    import cpu_core_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_isa_pkg::exec_op_e op,
    input  cpu_core_pkg::word_t   a,
    input  cpu_core_pkg::word_t   b,
    output cpu_core_pkg::word_t   y
);
    import cpu_isa_pkg::*;

    always_comb begin
        case (op)
            op_add, op_addi: y = a + b;
            op_sub:          y = a - b;
            op_slt:          y = {31'b0, ($signed(a) < $signed(b))};
            op_sltu:         y = {31'b0, (a < b)};
            op_and:          y = a & b;
            op_or:           y = a | b;
            op_nor:          y = ~(a | b);
            op_xor:          y = a ^ b;
            // shift amount is the low five bits
            op_sll:          y = a << b[4:0];
            op_srl:          y = a >> b[4:0];
            op_sra:          y = $signed(a) >>> b[4:0];
            op_lu12i:        y = b;
            default:         y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/shift_add_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
    input  logic         clk,
    input  logic         reset,
    exec_unit_if.unit_dp bus
);
    import cpu_core_pkg::*;

    typedef enum logic [1:0] {s_idle, s_run, s_fix, s_ack} state_e;

    state_e     state;
    logic [4:0] step;
    dword_t     mcand;
    dword_t     prod;
    word_t      mplier;
    logic       neg;
    word_t      mag1;
    word_t      mag2;

    assign mag1 = (bus.op.is_signed && bus.src1[xlen-1]) ? -bus.src1 : bus.src1;
    assign mag2 = (bus.op.is_signed && bus.src2[xlen-1]) ? -bus.src2 : bus.src2;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= s_idle;
            step    <= '0;
            bus.ack <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    step <= '0;
                    if (bus.req) state <= s_run;
                end
                s_run: begin
                    step <= step + 5'd1;
                    if (step == 5'd31) state <= s_fix;
                end
                s_fix: begin
                    bus.ack <= 1'b1;
                    state   <= s_ack;
                end
                default: begin
                    if (!bus.req) begin
                        bus.ack <= 1'b0;
                        state   <= s_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            s_idle: begin
                mcand  <= {{xlen{1'b0}}, mag1};
                mplier <= mag2;
                prod   <= '0;
                neg    <= bus.op.is_signed && (bus.src1[xlen-1] ^ bus.src2[xlen-1]);
            end
            s_run: begin
                if (mplier[0]) prod <= prod + mcand;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end
            s_fix: bus.result <= neg ? -prod : prod;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/restoring_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module restoring_divider (
    input  logic         clk,
    input  logic         reset,
    exec_unit_if.unit_dp bus
);
    import cpu_core_pkg::*;

    typedef enum logic [1:0] {s_idle, s_run, s_fix, s_ack} state_e;

    state_e        state;
    logic [4:0]    step;
    word_t         quo;
    word_t         rem;
    word_t         dvsr;
    logic [xlen:0] trial;
    logic          neg_q;
    logic          neg_r;
    word_t         mag1;
    word_t         mag2;

    assign mag1 = (bus.op.is_signed && bus.src1[xlen-1]) ? -bus.src1 : bus.src1;
    assign mag2 = (bus.op.is_signed && bus.src2[xlen-1]) ? -bus.src2 : bus.src2;

    // msb set on the shifted remainder minus divisor means restore
    assign trial = {rem, quo[xlen-1]} - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= s_idle;
            step    <= '0;
            bus.ack <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    step <= '0;
                    if (bus.req) state <= s_run;
                end
                s_run: begin
                    step <= step + 5'd1;
                    if (step == 5'd31) state <= s_fix;
                end
                s_fix: begin
                    bus.ack <= 1'b1;
                    state   <= s_ack;
                end
                default: begin
                    if (!bus.req) begin
                        bus.ack <= 1'b0;
                        state   <= s_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            s_idle: begin
                quo   <= mag1;
                rem   <= '0;
                dvsr  <= mag2;
                // divide by zero keeps the all-ones quotient unsigned
                neg_q <= bus.op.is_signed && (bus.src1[xlen-1] ^ bus.src2[xlen-1])
                         && (bus.src2 != '0);
                neg_r <= bus.op.is_signed && bus.src1[xlen-1];
            end
            s_run: begin
                if (!trial[xlen]) begin
                    rem <= trial[xlen-1:0];
                    quo <= {quo[xlen-2:0], 1'b1};
                end else begin
                    rem <= {rem[xlen-2:0], quo[xlen-1]};
                    quo <= {quo[xlen-2:0], 1'b0};
                end
            end
            s_fix: begin
                bus.result.quotient  <= neg_q ? -quo : quo;
                bus.result.remainder <= neg_r ? -rem : rem;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/issue_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  cpu_core_pkg::word_t    inst_pc,
    input  cpu_core_pkg::word_t    inst,
    output logic                   ack,
    output cpu_core_pkg::word_t    debug_wb_pc,
    output logic [3:0]             debug_wb_rf_we,
    output cpu_core_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_core_pkg::word_t    debug_wb_rf_wdata,
    output cpu_core_pkg::reg_idx_t raddr1,
    output cpu_core_pkg::reg_idx_t raddr2,
    input  cpu_core_pkg::word_t    rdata1,
    input  cpu_core_pkg::word_t    rdata2,
    output logic                   we,
    output cpu_core_pkg::reg_idx_t waddr,
    output cpu_core_pkg::word_t    wdata,
    output cpu_isa_pkg::exec_op_e  alu_op,
    output cpu_core_pkg::word_t    alu_a,
    output cpu_core_pkg::word_t    alu_b,
    input  cpu_core_pkg::word_t    alu_y,
    exec_unit_if.unit_ctrl         mul_bus,
    exec_unit_if.unit_ctrl         div_bus
);
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;

    typedef enum logic [2:0] {
        s_idle, s_read, s_wait_unit, s_done, s_release
    } state_e;

    state_e   state;
    word_t    inst_q;
    word_t    pc_q;
    word_t    res_q;
    exec_op_e op;
    word_t    imm;
    logic     is_mul;
    logic     is_div;
    logic     wen;

    always_comb begin
        case (inst_q[op3r_lo +: op3r_w])
            opc_add_w:   op = op_add;
            opc_sub_w:   op = op_sub;
            opc_slt:     op = op_slt;
            opc_sltu:    op = op_sltu;
            opc_nor:     op = op_nor;
            opc_and:     op = op_and;
            opc_or:      op = op_or;
            opc_xor:     op = op_xor;
            opc_sll_w:   op = op_sll;
            opc_srl_w:   op = op_srl;
            opc_sra_w:   op = op_sra;
            opc_mul_w:   op = op_mul;
            opc_mulh_w:  op = op_mulh;
            opc_mulh_wu: op = op_mulhu;
            opc_div_w:   op = op_div;
            opc_mod_w:   op = op_mod;
            opc_div_wu:  op = op_divu;
            opc_mod_wu:  op = op_modu;
            default:     op = op_none;
        endcase
        // immediate formats never collide with the 3R space
        if (inst_q[op2ri12_lo +: op2ri12_w] == opc_addi_w) begin
            op = op_addi;
        end
        if (inst_q[op1ri20_lo +: op1ri20_w] == opc_lu12i_w) begin
            op = op_lu12i;
        end
    end

    assign is_mul = op inside {op_mul, op_mulh, op_mulhu};
    assign is_div = op inside {op_div, op_mod, op_divu, op_modu};
    assign wen    = (op != op_none);

    assign imm = (op == op_lu12i) ? {inst_q[si20_lo +: 20], 12'b0}
                                  : {{20{inst_q[si12_lo + 11]}}, inst_q[si12_lo +: 12]};

    assign raddr1 = inst_q[rj_lo +: 5];
    assign raddr2 = inst_q[rk_lo +: 5];
    assign alu_op = op;
    assign alu_a  = rdata1;
    assign alu_b  = (op == op_addi || op == op_lu12i) ? imm : rdata2;

    assign mul_bus.op   = muldiv_op_t'{is_signed: (op != op_mulhu)};
    assign mul_bus.src1 = rdata1;
    assign mul_bus.src2 = rdata2;
    assign div_bus.op   = muldiv_op_t'{is_signed: (op == op_div || op == op_mod)};
    assign div_bus.src1 = rdata1;
    assign div_bus.src2 = rdata2;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= s_idle;
            mul_bus.req <= 1'b0;
            div_bus.req <= 1'b0;
        end else begin
            case (state)
                s_idle: if (req) state <= s_read;
                s_read: begin
                    mul_bus.req <= is_mul;
                    div_bus.req <= is_div;
                    state       <= s_wait_unit;
                end
                s_wait_unit: begin
                    // alu and undecoded ops pass straight through
                    if (mul_bus.ack || div_bus.ack || !(is_mul || is_div)) begin
                        mul_bus.req <= 1'b0;
                        div_bus.req <= 1'b0;
                        state       <= s_done;
                    end
                end
                s_done: state <= s_release;
                default: if (!req) state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && req) begin
            inst_q <= inst;
            pc_q   <= inst_pc;
        end
        if (state == s_read) begin
            res_q <= alu_y;
        end
        if (state == s_wait_unit && mul_bus.ack) begin
            res_q <= (op == op_mul) ? mul_bus.result[xlen-1:0]
                                    : mul_bus.result[2*xlen-1:xlen];
        end
        if (state == s_wait_unit && div_bus.ack) begin
            res_q <= (op == op_div || op == op_divu) ? div_bus.result.quotient
                                                     : div_bus.result.remainder;
        end
    end

    assign ack   = (state == s_done) || (state == s_release);
    assign we    = (state == s_done) && wen;
    assign waddr = inst_q[rd_lo +: 5];
    assign wdata = res_q;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_we    = we ? trace_we_ones : 4'b0;
    assign debug_wb_rf_wnum  = waddr;
    assign debug_wb_rf_wdata = res_q;

endmodule

`default_nettype wire

// ==== rtl/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  cpu_core_pkg::word_t    inst_pc,
    input  cpu_core_pkg::word_t    inst,
    output logic                   ack,
    output cpu_core_pkg::word_t    debug_wb_pc,
    output logic [3:0]             debug_wb_rf_we,
    output cpu_core_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_core_pkg::word_t    debug_wb_rf_wdata
);
    import cpu_core_pkg::*;
    import cpu_isa_pkg::*;

    reg_idx_t raddr1;
    reg_idx_t raddr2;
    word_t    rdata1;
    word_t    rdata2;
    logic     we;
    reg_idx_t waddr;
    word_t    wdata;
    exec_op_e alu_op;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_y;

    exec_unit_if #(.op_t(muldiv_op_t), .result_t(dword_t))      mul_bus ();
    exec_unit_if #(.op_t(muldiv_op_t), .result_t(div_result_t)) div_bus ();

    issue_control u_issue_control (.*);

    regfile u_regfile (.*);

    alu u_alu (
        .op (alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    shift_add_multiplier u_mul (
        .clk   (clk),
        .reset (reset),
        .bus   (mul_bus)
    );

    restoring_divider u_div (
        .clk   (clk),
        .reset (reset),
        .bus   (div_bus)
    );

endmodule

`default_nettype wire

// ==== testbench/exec_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core_checker (
    input logic       clk,
    input logic       reset,
    input logic       req,
    input logic       ack,
    input logic [3:0] debug_wb_rf_we,
    input logic       mul_req,
    input logic       div_req
);
    int failures = 0;

    // ack only drops once the host has let go of req
    ack_held: assert property (@(posedge clk) disable iff (reset) req && ack |=> ack)
        else begin
            failures++;
            $error("ack fell while req was high");
        end

    // one trace write per instruction in the ack rising cycle
    trace_single: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we != 4'b0 |-> $rose(ack))
        else begin
            failures++;
            $error("trace write enable outside the ack rising cycle");
        end

    reset_quiet: assert property (@(posedge clk) reset |=> !ack && !mul_req && !div_req)
        else begin
            failures++;
            $error("ack or a unit req high right after reset");
        end

endmodule

bind exec_core exec_core_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .req            (req),
    .ack            (ack),
    .debug_wb_rf_we (debug_wb_rf_we),
    .mul_req        (mul_bus.req),
    .div_req        (div_bus.req)
);

`default_nettype wire

// ==== testbench/exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;
    import cpu_core_pkg::*;

    logic       clk;
    logic       reset;
    logic       req;
    word_t      inst_pc;
    word_t      inst;
    logic       ack;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    integer seed;
    int     pattern_no;

    exec_core DUT (.*);

    always #2 clk = ~clk;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_error($sformatf("MISMATCH at %0t: pattern %0d %s expected %h actual %h",
                                $time, pattern_no, field, expected, actual));
    endtask

    // polls ack on falling edges and counts the cycles
    task automatic wait_for_ack(input logic level, output int cycles);
        cycles = 0;
        while (ack !== level) begin
            @(negedge clk);
            cycles++;
            assert (cycles <= 100) else stop_on_error($sformatf(
                "timeout at %0t: ack did not go to %0b within 100 cycles", $time, level));
        end
    endtask

    task automatic run_instruction(input word_t pc, input word_t inst_word, input logic write,
                                   input reg_idx_t wnum, input word_t wdata);
        int   hold;
        int   gap;
        int   cycles;
        logic is_muldiv;
        is_muldiv = inst_word[31:15] inside {[17'h38:17'h3a], [17'h40:17'h43]};
        req     = 1'b1;
        inst_pc = pc;
        inst    = inst_word;
        wait_for_ack(1'b1, cycles);
        // alu and undecoded ops show ack on the third falling edge
        if (!is_muldiv) begin
            assert (cycles == 3) else report_mismatch("ack latency", 3, cycles);
        end
        assert (debug_wb_rf_we === (write ? trace_we_ones : 4'b0))
            else report_mismatch("debug_wb_rf_we", write ? trace_we_ones : 4'b0, debug_wb_rf_we);
        if (write) begin
            assert (debug_wb_pc === pc)
                else report_mismatch("debug_wb_pc", pc, debug_wb_pc);
            assert (debug_wb_rf_wnum === wnum)
                else report_mismatch("debug_wb_rf_wnum", wnum, debug_wb_rf_wnum);
            assert (debug_wb_rf_wdata === wdata)
                else report_mismatch("debug_wb_rf_wdata", wdata, debug_wb_rf_wdata);
        end
        // hold req past ack for a few cycles
        hold = {$random(seed)} % 3;
        repeat (hold) begin
            @(negedge clk);
            assert (ack === 1'b1) else stop_on_error($sformatf(
                "ack dropped at %0t while req was still high", $time));
            assert (debug_wb_rf_we === 4'b0)
                else report_mismatch("debug_wb_rf_we while held", 0, debug_wb_rf_we);
        end
        req = 1'b0;
        wait_for_ack(1'b0, cycles);
        gap = {$random(seed)} % 4;
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        word_t       pc;
        word_t       inst_word;
        word_t       wdata;
        logic [31:0] write;
        logic [31:0] wnum;
        clk        = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        inst_pc    = '0;
        inst       = '0;
        seed       = 32'h3aa5;
        pattern_no = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("testbench/exec_core_patterns.hex", "r");
        assert (fd != 0) else stop_on_error("could not open testbench/exec_core_patterns.hex");
        while ($fgets(line, fd) != 0) begin
            // comment lines do not scan as five hex fields
            fields = $sscanf(line, "%h %h %h %h %h", pc, inst_word, write, wnum, wdata);
            if (fields == 5) begin
                pattern_no++;
                run_instruction(pc, inst_word, write[0], wnum[4:0], wdata);
            end
        end
        $fclose(fd);
        repeat (2) @(negedge clk);

        assert (pattern_no > 0) else stop_on_error("the pattern file held no instructions");
        if (DUT.u_checker.failures == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_on_error($sformatf("bound checker saw %0d assertion failures",
                                    DUT.u_checker.failures));
        end
    end

endmodule

`default_nettype wire

// ==== testbench/exec_core_patterns.hex ====
// pc       inst     we wnum wdata
// we is 1 when the instruction must write wnum with wdata
1c000000 142468a1 1 01 12345000
1c000004 0299e021 1 01 12345678
1c000008 02bfe402 1 02 fffffff9
1c00000c 15000003 1 03 80000000
1c000010 02801404 1 04 00000005
1c000014 00100825 1 05 12345671
1c000018 00110446 1 06 edcba981
1c00001c 00121047 1 07 00000001
1c000020 00129048 1 08 00000000
1c000024 00140829 1 09 00000006
1c000028 0014942a 1 0a 12345670
1c00002c 0015106b 1 0b 80000005
1c000030 0015982c 1 0c fffffff9
1c000034 0017102d 1 0d 468acf00
1c000038 0017886e 1 0e 00000040
1c00003c 0018086f 1 0f ffffffc0
1c000040 001c0830 1 10 8091a2b8
1c000044 001c8831 1 11 ffffffff
1c000048 001d0832 1 12 12345677
1c00004c 001c8c73 1 13 40000000
1c000050 00200834 1 14 fd663ccb
1c000054 00209055 1 15 fffffffe
1c000058 00211056 1 16 33333331
1c00005c 00219057 1 17 00000004
1c000060 00200038 1 18 ffffffff
1c000064 00208059 1 19 fffffff9
1c000068 0020883b 1 1b 00000005
1c00006c 02800420 1 00 12345679
1c000070 0010101a 1 1a 00000005
1c000074 ffffffff 0 00 00000000

// ==== exec_core.f ====
rtl/cpu_core_pkg.sv
rtl/cpu_isa_pkg.sv
rtl/exec_unit_if.sv
rtl/regfile.sv
rtl/alu.sv
rtl/shift_add_multiplier.sv
rtl/restoring_divider.sv
rtl/issue_control.sv
rtl/exec_core.sv
testbench/exec_core_checker.sv
testbench/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - rtl/cpu_core_pkg.sv
  - rtl/cpu_isa_pkg.sv
  - rtl/exec_unit_if.sv
  - rtl/regfile.sv
  - rtl/alu.sv
  - rtl/shift_add_multiplier.sv
  - rtl/restoring_divider.sv
  - rtl/issue_control.sv
  - rtl/exec_core.sv
  - target: test
    files:
      - testbench/exec_core_checker.sv
      - testbench/exec_core_tb.sv
